// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pipeCoreTb
FILELIST = pipeCore.f

SOURCES  = $(shell cat $(FILELIST))
BINARY   = obj_dir/V$(TOP)
PASS     = All checks passed

.PHONY: all run clean

all: $(BINARY)

# Rebuilt only when a source or the file list changes.
$(BINARY): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

// File: bench/pipeCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCoreTb;
    import pipeCorePkg::*;

    localparam int COMMIT_TIMEOUT = 200;
    localparam int RESET_CYCLES   = 3;

    logic                      clk = 1'b0;
    logic                      resetn;
    logic                      imemWrite;
    logic [PC_WIDTH-1:0]       imemAddr;
    logic [INSTR_WIDTH-1:0]    imemData;
    logic                      commitValid;
    logic [PC_WIDTH-1:0]       commitPc;
    logic [REG_ADDR_WIDTH-1:0] commitRd;
    logic [DATA_WIDTH-1:0]     commitValue;
    logic                      commitReady = 1'b0;

    logic [INSTR_WIDTH-1:0]    progTable [$];
    logic [PC_WIDTH-1:0]       expPc [$];
    logic [REG_ADDR_WIDTH-1:0] expRd [$];
    logic [DATA_WIDTH-1:0]     expValue [$];

    integer                    seed = 32'hfe93_aeb2;
    int                        valueErrors = 0;
    int                        protocolErrors = 0;
    logic                      wasStalled = 1'b0;
    logic [PC_WIDTH-1:0]       heldPc;
    logic [REG_ADDR_WIDTH-1:0] heldRd;
    logic [DATA_WIDTH-1:0]     heldValue;

    pipeCore pipeCore_i (
        .clk, .resetn, .imemWrite, .imemAddr, .imemData,
        .commitValid, .commitPc, .commitRd, .commitValue, .commitReady
    );

    always #4 clk = ~clk;

    // Ready about 60 percent of the time.
    always @(posedge clk) begin
        commitReady <= ({$random(seed)} % 100) < 60;
    end

    // ****************************************
    // Helpers.
    // ****************************************
    function automatic logic [INSTR_WIDTH-1:0] encodeReg(opcode_e op, int rd, int rs, int rt);
        return {op, REG_ADDR_WIDTH'(rd), REG_ADDR_WIDTH'(rs), 3'b000, REG_ADDR_WIDTH'(rt)};
    endfunction

    function automatic logic [INSTR_WIDTH-1:0] encodeImm(opcode_e op, int rd, int rs, int imm);
        return {op, REG_ADDR_WIDTH'(rd), REG_ADDR_WIDTH'(rs), IMM_WIDTH'(imm)};
    endfunction

    task automatic addExpect(input int pc, input int rd, input int value);
        expPc.push_back(PC_WIDTH'(pc));
        expRd.push_back(REG_ADDR_WIDTH'(rd));
        expValue.push_back(DATA_WIDTH'(value));
    endtask

    task automatic reportMismatch(input string name, input logic [DATA_WIDTH-1:0] got,
                                  input logic [DATA_WIDTH-1:0] want);
        valueErrors++;
        $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
    endtask

    // ****************************************
    // Program and expected commits.
    // ****************************************
    task automatic buildTables();
        progTable.push_back(encodeImm(OP_LI, 1, 0, 5));    // r1 = 5.
        progTable.push_back(encodeImm(OP_ADDI, 1, 1, 3));  // r1 = 8.
        progTable.push_back(encodeReg(OP_ADD, 2, 1, 1));   // r2 = 16.
        progTable.push_back(encodeReg(OP_SUB, 3, 2, 1));   // r3 = 8.
        progTable.push_back(encodeReg(OP_XOR, 4, 3, 2));   // r4 = 24.
        progTable.push_back(encodeReg(OP_AND, 5, 4, 2));   // r5 = 16.
        progTable.push_back(encodeImm(OP_LI, 6, 0, -4));   // r6 = 0xfffc.
        progTable.push_back(encodeReg(OP_ADD, 7, 6, 5));   // r7 = 12 after wrapping.
        progTable.push_back(encodeImm(OP_LI, 0, 0, 9));    // r0 stays zero.
        progTable.push_back(encodeImm(OP_ADDI, 1, 0, 7));  // r1 = 0 + 7.
        progTable.push_back(encodeReg(OP_NOP, 0, 0, 0));   // Plain NOP.
        progTable.push_back(encodeImm(OP_BEQ, 1, 3, 2));   // 7 != 8 so it falls through.
        progTable.push_back(encodeImm(OP_BEQ, 2, 5, 2));   // Taken to pc 15.
        progTable.push_back(encodeImm(OP_LI, 1, 0, 31));   // Squashed.
        progTable.push_back(encodeImm(OP_LI, 2, 0, 31));   // Squashed.
        progTable.push_back(encodeReg(OP_SUB, 4, 0, 7));   // r4 = 0xfff4.
        progTable.push_back(encodeImm(OP_ADDI, 4, 4, -2)); // r4 = 0xfff2.
        progTable.push_back(encodeImm(OP_BEQ, 4, 4, 2));   // Taken to pc 20.
        progTable.push_back(encodeImm(OP_LI, 5, 0, 1));    // Squashed.
        progTable.push_back(encodeImm(OP_LI, 6, 0, 1));    // Squashed.
        progTable.push_back(encodeReg(OP_XOR, 5, 4, 6));   // r5 = 0x000e.
        progTable.push_back(encodeImm(OP_BEQ, 0, 0, -1));  // Self-loop.

        addExpect(0, 1, 5);
        addExpect(1, 1, 8);
        addExpect(2, 2, 16);
        addExpect(3, 3, 8);
        addExpect(4, 4, 24);
        addExpect(5, 5, 16);
        addExpect(6, 6, 'hfffc);
        addExpect(7, 7, 12);
        addExpect(8, 0, 9);
        addExpect(9, 1, 7);
        addExpect(10, 0, 0);
        addExpect(11, 0, 0);
        addExpect(12, 0, 0);
        addExpect(15, 4, 'hfff4);
        addExpect(16, 4, 'hfff2);
        addExpect(17, 0, 0);
        addExpect(20, 5, 'h000e);
        addExpect(21, 0, 0);
        addExpect(21, 0, 0);  // Loop comes round again.
    endtask

    // Unused words become NOPs tagged with their address.
    task automatic loadProgram();
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            @(posedge clk);
            imemWrite <= 1'b1;
            imemAddr  <= PC_WIDTH'(a);
            if (a < progTable.size()) begin
                imemData <= progTable[a];
            end else begin
                imemData <= {OP_NOP, 6'b0, PC_WIDTH'(a)};
            end
        end
        @(posedge clk);
        imemWrite <= 1'b0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            assert (!commitValid) else begin
                protocolErrors++;
                $display("commitValid went high during reset at %0t", $time);
            end
        end
        @(posedge clk);
        resetn <= 1'b1;
    endtask

    // Returns at the negedge before the edge that takes the commit.
    task automatic waitForCommit(output logic timedOut);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(commitValid && commitReady) && (cycles < COMMIT_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        timedOut = !(commitValid && commitReady);
    endtask

    // ****************************************
    // Commit port must hold while stalled.
    // ****************************************
    always @(negedge clk) begin
        if (resetn && wasStalled) begin
            assert (commitValid) else begin
                protocolErrors++;
                $display("commitValid dropped while the port was stalled at %0t", $time);
            end
            assert (commitPc == heldPc) else
                reportMismatch("commitPc held", DATA_WIDTH'(commitPc), DATA_WIDTH'(heldPc));
            assert (commitRd == heldRd) else
                reportMismatch("commitRd held", DATA_WIDTH'(commitRd), DATA_WIDTH'(heldRd));
            assert (commitValue == heldValue) else
                reportMismatch("commitValue held", commitValue, heldValue);
        end
        wasStalled = commitValid && !commitReady;
        heldPc     = commitPc;
        heldRd     = commitRd;
        heldValue  = commitValue;
    end

    initial begin
        logic timedOut;
        resetn    = 1'b0;
        imemWrite = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        buildTables();
        loadProgram();

        for (int i = 0; i < expPc.size(); i++) begin
            waitForCommit(timedOut);
            if (timedOut) begin
                protocolErrors++;
                $display("No commit arrived for entry %0d within %0d cycles, at %0t",
                         i, COMMIT_TIMEOUT, $time);
                break;
            end
            assert (commitPc == expPc[i]) else
                reportMismatch("commitPc", DATA_WIDTH'(commitPc), DATA_WIDTH'(expPc[i]));
            assert (commitRd == expRd[i]) else
                reportMismatch("commitRd", DATA_WIDTH'(commitRd), DATA_WIDTH'(expRd[i]));
            assert (commitValue == expValue[i]) else
                reportMismatch("commitValue", commitValue, expValue[i]);
        end

        $display("Errors: %0d value mismatches, %0d protocol failures",
                 valueErrors, protocolErrors);
        if ((valueErrors + protocolErrors) == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pipeCore.f
source/pipeCorePkg.sv
source/stageRegs.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/hazardUnit.sv
source/pipeCore.sv
bench/pipeCoreTb.sv

// File: source/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  pipeCorePkg::fetchData_t                fetchData,
    input  logic                                   commitWrite,
    input  logic [pipeCorePkg::REG_ADDR_WIDTH-1:0] commitRd,
    input  logic [pipeCorePkg::DATA_WIDTH-1:0]     commitValue,
    output pipeCorePkg::decodeData_t               decodeData,
    output logic [pipeCorePkg::REG_ADDR_WIDTH-1:0] srcA,
    output logic [pipeCorePkg::REG_ADDR_WIDTH-1:0] srcB,
    output logic                                   usesA,
    output logic                                   usesB
);
    import pipeCorePkg::*;

    logic [DATA_WIDTH-1:0]     regFile [REG_COUNT];
    logic [OPCODE_WIDTH-1:0]   rawOp;
    opcode_e                   op;
    logic [REG_ADDR_WIDTH-1:0] rd, rs, rt;
    logic                      writesReg;
    logic                      useRdAsB;

    // Register 0 reads as zero and commit data bypasses the array.
    function automatic logic [DATA_WIDTH-1:0] readReg(input logic [REG_ADDR_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (commitWrite && (commitRd == addr)) begin
            value = commitValue;
        end else begin
            value = regFile[addr];
        end
        return value;
    endfunction

    assign rawOp = fetchData.instr[OPCODE_MSB:OPCODE_LSB];
    assign rd    = fetchData.instr[RD_MSB:RD_LSB];
    assign rs    = fetchData.instr[RS_MSB:RS_LSB];
    assign rt    = fetchData.instr[RT_MSB:RT_LSB];

    // ****************************************
    // Opcode decode.
    // ****************************************
    always_comb begin
        op        = OP_NOP;  // Unknown opcodes behave as NOP.
        writesReg = 1'b0;
        usesA     = 1'b0;
        usesB     = 1'b0;
        useRdAsB  = 1'b0;
        case (rawOp)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                op        = opcode_e'(rawOp);
                writesReg = 1'b1;
                usesA     = 1'b1;
                usesB     = 1'b1;
            end
            OP_ADDI: begin
                op        = OP_ADDI;
                writesReg = 1'b1;
                usesA     = 1'b1;
            end
            OP_LI: begin
                op        = OP_LI;
                writesReg = 1'b1;
            end
            OP_BEQ: begin
                op       = OP_BEQ;
                usesA    = 1'b1;
                usesB    = 1'b1;
                useRdAsB = 1'b1;  // Compares rd with rs.
            end
            default: ;
        endcase
    end

    assign srcA = rs;
    assign srcB = useRdAsB ? rd : rt;

    // ****************************************
    // Register file.
    // ****************************************
    always_ff @(posedge clk) begin
        if (~resetn) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (commitWrite && (commitRd != '0)) begin
            regFile[commitRd] <= commitValue;
        end
    end

    always_comb begin
        decodeData.valid     = fetchData.valid;
        decodeData.pc        = fetchData.pc;
        decodeData.op        = op;
        decodeData.rd        = rd;
        decodeData.operandA  = readReg(srcA);
        decodeData.operandB  = readReg(srcB);
        decodeData.imm       = fetchData.instr[IMM_MSB:IMM_LSB];
        decodeData.writesReg = writesReg & fetchData.valid;
    end

endmodule

`default_nettype wire

// File: source/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  pipeCorePkg::decodeData_t         decodeData,
    output pipeCorePkg::execData_t           execData,
    output logic                             branchTaken,
    output logic [pipeCorePkg::PC_WIDTH-1:0] branchTarget
);
    import pipeCorePkg::*;

    logic [DATA_WIDTH-1:0] immExt;
    logic [DATA_WIDTH-1:0] aluB;
    logic [DATA_WIDTH-1:0] aluResult;
    logic                  immSelect;

    // ****************************************
    // Immediate and operand select.
    // ****************************************
    assign immExt = {{(DATA_WIDTH - IMM_WIDTH){decodeData.imm[IMM_WIDTH-1]}}, decodeData.imm};

    assign immSelect = (decodeData.op == OP_ADDI) || (decodeData.op == OP_LI);
    assign aluB      = immSelect ? immExt : decodeData.operandB;

    // ****************************************
    // ALU.
    // ****************************************
    always_comb begin
        case (decodeData.op)
            OP_ADD, OP_ADDI: aluResult = decodeData.operandA + aluB;
            OP_SUB:          aluResult = decodeData.operandA - aluB;
            OP_AND:          aluResult = decodeData.operandA & aluB;
            OP_XOR:          aluResult = decodeData.operandA ^ aluB;
            OP_LI:           aluResult = aluB;
            default:         aluResult = '0;
        endcase
    end

    // Branch resolution.
    assign branchTaken = decodeData.valid && (decodeData.op == OP_BEQ) &&
                         (decodeData.operandA == decodeData.operandB);

    // Target wraps within the 64-word memory.
    assign branchTarget = decodeData.pc + PC_WIDTH'(1) + immExt[PC_WIDTH-1:0];

    // Non-writing ops commit rd 0 and value 0.
    always_comb begin
        execData.valid     = decodeData.valid;
        execData.pc        = decodeData.pc;
        execData.writesReg = decodeData.writesReg;
        if (decodeData.writesReg) begin
            execData.rd     = decodeData.rd;
            execData.result = aluResult;
        end else begin
            execData.rd     = '0;
            execData.result = '0;
        end
    end

endmodule

`default_nettype wire

// File: source/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
    input  logic                                clk,
    input  logic [pipeCorePkg::PC_WIDTH-1:0]    pc,
    input  logic                                branchTaken,
    input  logic [pipeCorePkg::PC_WIDTH-1:0]    branchTarget,
    input  logic                                imemWrite,
    input  logic [pipeCorePkg::PC_WIDTH-1:0]    imemAddr,
    input  logic [pipeCorePkg::INSTR_WIDTH-1:0] imemData,
    output logic [pipeCorePkg::PC_WIDTH-1:0]    pcNew,
    output pipeCorePkg::fetchData_t             fetchData
);
    import pipeCorePkg::*;

    logic [INSTR_WIDTH-1:0] imem [IMEM_DEPTH];

    // ****************************************
    // Instruction memory.
    // ****************************************

    // Loaded from outside while the core sits in reset.
    always_ff @(posedge clk) begin
        if (imemWrite) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_comb begin
        fetchData.valid = 1'b1;
        fetchData.pc    = pc;
        fetchData.instr = imem[pc];  // Asynchronous read.
    end

    // ****************************************
    // Next pc.
    // ****************************************
    always_comb begin
        if (branchTaken) begin
            pcNew = branchTarget;  // Redirect from execute.
        end else begin
            pcNew = pc + PC_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

// File: source/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
    input  logic [pipeCorePkg::REG_ADDR_WIDTH-1:0] srcA,
    input  logic [pipeCorePkg::REG_ADDR_WIDTH-1:0] srcB,
    input  logic                                   usesA,
    input  logic                                   usesB,
    input  logic                                   decodeValid,
    input  logic [pipeCorePkg::REG_ADDR_WIDTH-1:0] execDest,
    input  logic                                   execWrites,
    input  logic [pipeCorePkg::REG_ADDR_WIDTH-1:0] wbDest,
    input  logic                                   wbWrites,
    input  logic                                   branchTaken,
    input  logic                                   commitValid,
    input  logic                                   commitReady,
    output logic                                   stallF,
    output logic                                   stallD,
    output logic                                   flushD,
    output logic                                   stallE,
    output logic                                   flushE,
    output logic                                   stallW
);
    logic commitStall;
    logic commitTaken;
    logic execHit;
    logic wbHit;
    logic dataHazard;

    assign commitStall = commitValid & ~commitReady;
    assign commitTaken = commitValid & commitReady;

    // ****************************************
    // Read-after-write detection.
    // ****************************************
    assign execHit = execWrites &&
                     ((usesA && (srcA != '0) && (srcA == execDest)) ||
                      (usesB && (srcB != '0) && (srcB == execDest)));

    // A committing producer is picked up by write-through.
    assign wbHit = wbWrites && !commitTaken &&
                   ((usesA && (srcA != '0) && (srcA == wbDest)) ||
                    (usesB && (srcB != '0) && (srcB == wbDest)));

    assign dataHazard = decodeValid & (execHit | wbHit);

    // ****************************************
    // Stall and flush.
    // ****************************************
    assign stallW = commitStall;
    assign stallE = commitStall;
    assign flushE = ~commitStall & (branchTaken | dataHazard);  // Bubble or squash.
    assign flushD = ~commitStall & branchTaken;
    assign stallD = commitStall | (dataHazard & ~branchTaken);  // Branch wins.
    assign stallF = commitStall | (dataHazard & ~branchTaken);

endmodule

`default_nettype wire

// File: source/pipeCore.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCore (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   imemWrite,
    input  logic [pipeCorePkg::PC_WIDTH-1:0]       imemAddr,
    input  logic [pipeCorePkg::INSTR_WIDTH-1:0]    imemData,
    output logic                                   commitValid,
    output logic [pipeCorePkg::PC_WIDTH-1:0]       commitPc,
    output logic [pipeCorePkg::REG_ADDR_WIDTH-1:0] commitRd,
    output logic [pipeCorePkg::DATA_WIDTH-1:0]     commitValue,
    input  logic                                   commitReady
);
    import pipeCorePkg::*;

    logic [PC_WIDTH-1:0]       pc, pcNew;
    fetchData_t                fetchDataNew, fetchData;
    decodeData_t               decodeDataNew, decodeData;
    execData_t                 execDataNew, commitData;
    logic                      branchTaken;
    logic [PC_WIDTH-1:0]       branchTarget;
    logic [REG_ADDR_WIDTH-1:0] srcA, srcB;
    logic                      usesA, usesB;
    logic                      commitWrite;
    logic                      stallF, stallD, flushD, stallE, flushE, stallW;

    // ****************************************
    // Pipeline.
    // ****************************************
    fetchReg fetchReg_i (.clk, .resetn, .stall(stallF), .dataNew(pcNew), .data(pc));

    fetchStage fetchStage_i (
        .clk, .pc, .branchTaken, .branchTarget,
        .imemWrite, .imemAddr, .imemData,
        .pcNew, .fetchData(fetchDataNew)
    );

    decodeReg decodeReg_i (
        .clk, .resetn, .stall(stallD), .flush(flushD),
        .dataNew(fetchDataNew), .data(fetchData)
    );

    decodeStage decodeStage_i (
        .clk, .resetn, .fetchData,
        .commitWrite, .commitRd, .commitValue,
        .decodeData(decodeDataNew), .srcA, .srcB, .usesA, .usesB
    );

    executeReg executeReg_i (
        .clk, .resetn, .stall(stallE), .flush(flushE),
        .dataNew(decodeDataNew), .data(decodeData)
    );

    executeStage executeStage_i (
        .decodeData, .execData(execDataNew), .branchTaken, .branchTarget
    );

    writebackReg writebackReg_i (
        .clk, .resetn, .stall(stallW), .flush(1'b0),
        .dataNew(execDataNew), .data(commitData)
    );

    hazardUnit hazardUnit_i (
        .srcA, .srcB, .usesA, .usesB,
        .decodeValid(fetchData.valid),
        .execDest(decodeData.rd), .execWrites(decodeData.valid & decodeData.writesReg),
        .wbDest(commitData.rd), .wbWrites(commitData.valid & commitData.writesReg),
        .branchTaken, .commitValid, .commitReady,
        .stallF, .stallD, .flushD, .stallE, .flushE, .stallW
    );

    // Commit port.
    assign commitValid = commitData.valid;
    assign commitPc    = commitData.pc;
    assign commitRd    = commitData.rd;
    assign commitValue = commitData.result;
    assign commitWrite = commitValid & commitReady & commitData.writesReg;

endmodule

`default_nettype wire

// File: source/pipeCorePkg.sv
`default_nettype none

package pipeCorePkg;

    // ****************************************
    // Widths.
    // ****************************************
    localparam int DATA_WIDTH     = 16;
    localparam int INSTR_WIDTH    = 16;
    localparam int PC_WIDTH       = 6;
    localparam int IMEM_DEPTH     = 1 << PC_WIDTH;
    localparam int REG_COUNT      = 8;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int IMM_WIDTH      = 6;
    localparam int OPCODE_WIDTH   = 4;

    // ****************************************
    // Instruction format.
    // ****************************************
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int RD_MSB     = 11;
    localparam int RD_LSB     = 9;
    localparam int RS_MSB     = 8;
    localparam int RS_LSB     = 6;
    localparam int IMM_MSB    = 5;
    localparam int IMM_LSB    = 0;
    localparam int RT_MSB     = 2;  // Shares the low immediate bits.
    localparam int RT_LSB     = 0;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LI   = 4'h6,
        OP_BEQ  = 4'h7
    } opcode_e;

    // ****************************************
    // Stage payloads.
    // ****************************************
    typedef struct packed {
        logic                   valid;
        logic [PC_WIDTH-1:0]    pc;
        logic [INSTR_WIDTH-1:0] instr;
    } fetchData_t;

    typedef struct packed {
        logic                      valid;
        logic [PC_WIDTH-1:0]       pc;
        opcode_e                   op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [DATA_WIDTH-1:0]     operandA;
        logic [DATA_WIDTH-1:0]     operandB;
        logic [IMM_WIDTH-1:0]      imm;     // Raw field extended in execute.
        logic                      writesReg;
    } decodeData_t;

    typedef struct packed {
        logic                      valid;
        logic [PC_WIDTH-1:0]       pc;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [DATA_WIDTH-1:0]     result;
        logic                      writesReg;
    } execData_t;

endpackage

`default_nettype wire

// File: source/stageRegs.sv
`timescale 1ns/1ns
`default_nettype none

// ****************************************
// Fetch register holding the pc.
// ****************************************
module fetchReg (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             stall,
    input  logic [pipeCorePkg::PC_WIDTH-1:0] dataNew,
    output logic [pipeCorePkg::PC_WIDTH-1:0] data
);
    always_ff @(posedge clk) begin
        if (~resetn) begin
            data <= '0;  // Restart at pc 0.
        end else if (~stall) begin
            data <= dataNew;
        end
    end
endmodule

// ****************************************
// Decode register.
// ****************************************
module decodeReg (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    stall,
    input  logic                    flush,
    input  pipeCorePkg::fetchData_t dataNew,
    output pipeCorePkg::fetchData_t data
);
    always_ff @(posedge clk) begin
        if (~resetn | flush) begin
            data <= '0;
        end else if (~stall) begin
            data <= dataNew;
        end
    end
endmodule

// ****************************************
// Execute register.
// ****************************************
module executeReg (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     stall,
    input  logic                     flush,
    input  pipeCorePkg::decodeData_t dataNew,
    output pipeCorePkg::decodeData_t data
);
    always_ff @(posedge clk) begin
        if (~resetn | flush) begin
            data <= '0;  // Bubble.
        end else if (~stall) begin
            data <= dataNew;
        end
    end
endmodule

// ****************************************
// Writeback register feeding the commit port.
// ****************************************
module writebackReg (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   stall,
    input  logic                   flush,
    input  pipeCorePkg::execData_t dataNew,
    output pipeCorePkg::execData_t data
);
    always_ff @(posedge clk) begin
        if (~resetn | flush) begin
            data <= '0;
        end else if (~stall) begin
            data <= dataNew;
        end
    end
endmodule

`default_nettype wire
